/* emesh_defs.svh */
// Build-time sizing for the mesh CDC bridge
// EMESH_FIFO_DEPTH must be a power of two and equal 2**EMESH_FIFO_AW
`ifndef EMESH_DEFS_SVH
`define EMESH_DEFS_SVH

// Packet width in bits
`define EMESH_DW          104

// Entries per channel FIFO
`define EMESH_FIFO_DEPTH  16

// Address bits, pointers carry one extra wrap bit
`define EMESH_FIFO_AW     4

// Free entries still left when almost-full rises
// Sized for writes already in flight after wait_out
`define EMESH_PROG_MARGIN 4

`endif

/* emesh_pkg.sv */
// Shared mesh packet types
// Field order fixes the 104-bit layout on the wire, write flag in the MSB
package emesh_pkg;

  // Access size
  typedef enum logic [1:0] {
    DM_BYTE   = 2'b00, // 8 bit
    DM_HALF   = 2'b01, // 16 bit
    DM_WORD   = 2'b10, // 32 bit
    DM_DOUBLE = 2'b11  // 64 bit, data and srcaddr as a pair
  } datamode_t;

  // One mesh transaction
  typedef struct packed {
    logic        write;    // 1 = write, 0 = read request
    datamode_t   datamode;
    logic [4:0]  ctrlmode; // Passed through untouched
    logic [31:0] dstaddr;
    logic [31:0] data;
    logic [31:0] srcaddr;  // Return address for reads
  } emesh_packet_t;

endpackage

/* fifo_async.sv */
// Dual-clock FIFO with gray pointers and two-flop synchronizers
// DEPTH must be 2**AW; prog_full is pessimistic since it sees a delayed read pointer
// Read data is registered and updates only on an accepted read
`timescale 1ns/1ps

module fifo_async #(
  parameter int DW     = 104,
  parameter int DEPTH  = 16, // Power of two
  parameter int AW     = 4,  // log2(DEPTH)
  parameter int MARGIN = 4   // Free slots left when prog_full rises
) (
  input  logic          wr_clk,
  input  logic          wr_rst,
  input  logic          wr_en,
  input  logic [DW-1:0] din,
  input  logic          rd_clk,
  input  logic          rd_rst,
  input  logic          rd_en,
  output logic [DW-1:0] dout,
  output logic          empty,
  output logic          prog_full
);

  // Entry storage
  logic [DW-1:0] mem [DEPTH];

  // Write domain
  logic [AW:0] wr_bin;      // Binary write pointer with wrap bit
  logic [AW:0] wr_bin_next;
  logic [AW:0] wr_gray;     // Crosses to read side
  logic [AW:0] rd_gray_s1;  // Sync stage 1
  logic [AW:0] rd_gray_s2;  // Sync stage 2
  logic [AW:0] rd_bin_wr;   // Read pointer seen by writer
  logic [AW:0] wr_count;    // Occupancy as the writer sees it
  logic        full;
  logic        wr_ok;

  // Read domain
  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_next;
  logic [AW:0] rd_gray;     // Crosses to write side
  logic [AW:0] wr_gray_s1;
  logic [AW:0] wr_gray_s2;
  logic        rd_ok;

  // Gray to binary, MSB down
  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Occupancy from own pointer and synced far pointer
  assign rd_bin_wr   = gray2bin(rd_gray_s2);
  assign wr_count    = wr_bin - rd_bin_wr;   // Wraps correctly mod 2**(AW+1)
  assign full        = (wr_count == (AW+1)'(DEPTH));
  assign prog_full   = (wr_count >= (AW+1)'(DEPTH - MARGIN));
  assign wr_ok       = wr_en & ~full;        // Drop writes only when truly full
  assign wr_bin_next = wr_bin + (AW+1)'(1);

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (wr_ok) begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_bin_next ^ (wr_bin_next >> 1); // Registered gray so the crossing is glitch free
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_ok) begin
      mem[wr_bin[AW-1:0]] <= din;
    end
  end

  // Read pointer into write clock
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // Empty when pointers match exactly including the wrap bit
  assign empty       = (rd_gray == wr_gray_s2);
  assign rd_ok       = rd_en & ~empty;
  assign rd_bin_next = rd_bin + (AW+1)'(1);

  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_ok) begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
    end
  end

  // Read data register holds between reads
  always_ff @(posedge rd_clk) begin
    if (rd_ok) begin
      dout <= mem[rd_bin[AW-1:0]];
    end
  end

  // Write pointer into read clock
  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1; // Empty falls 2 to 3 read edges after a write
    end
  end

endmodule

/* fifo_cdc.sv */
// One packet crossing from clk_in to clk_out with access/wait strobes
// Sender must drop access_in soon after wait_out; margin covers a few late writes
`timescale 1ns/1ps
`include "emesh_defs.svh"

module fifo_cdc (
  // Write side
  input  logic                    clk_in,
  input  logic                    reset_in,
  input  logic                    access_in,
  input  emesh_pkg::emesh_packet_t packet_in,
  output logic                    wait_out,
  // Read side
  input  logic                    clk_out,
  input  logic                    reset_out,
  output logic                    access_out,
  output emesh_pkg::emesh_packet_t packet_out,
  input  logic                    wait_in
);

  logic                 wr_en;
  logic                 rd_en;
  logic                 empty;
  logic                 prog_full;
  logic [`EMESH_DW-1:0] fifo_dout;

  assign wr_en    = access_in;               // Not gated by full, margin absorbs it
  assign rd_en    = ~empty & ~wait_in;       // Pull only when receiver is free
  assign wait_out = prog_full;

  // Hold access until the receiver takes it
  always_ff @(posedge clk_out) begin
    if (reset_out) begin
      access_out <= 1'b0;
    end else if (!wait_in) begin
      access_out <= rd_en; // Lines up with the registered dout
    end
  end

  assign packet_out = emesh_pkg::emesh_packet_t'(fifo_dout);

  fifo_async #(
    .DW     (`EMESH_DW),
    .DEPTH  (`EMESH_FIFO_DEPTH),
    .AW     (`EMESH_FIFO_AW),
    .MARGIN (`EMESH_PROG_MARGIN)
  ) u_fifo (
    .wr_clk    (clk_in),
    .wr_rst    (reset_in),
    .wr_en     (wr_en),
    .din       (packet_in),
    .rd_clk    (clk_out),
    .rd_rst    (reset_out),
    .rd_en     (rd_en),
    .dout      (fifo_dout),
    .empty     (empty),
    .prog_full (prog_full)
  );

endmodule

/* emesh_cdc_bridge.sv */
// Bidirectional mesh bridge between clk_in and clk_out
// Each reset is synchronous to its own clock; assert both together
`timescale 1ns/1ps

module emesh_cdc_bridge (
  input  logic                     clk_in,
  input  logic                     reset_in,
  input  logic                     clk_out,
  input  logic                     reset_out,
  // Request path from clk_in to clk_out
  input  logic                     req_access_in,
  input  emesh_pkg::emesh_packet_t req_packet_in,
  output logic                     req_wait_out,
  output logic                     req_access_out,
  output emesh_pkg::emesh_packet_t req_packet_out,
  input  logic                     req_wait_in,
  // Response path from clk_out back to clk_in
  input  logic                     rsp_access_in,
  input  emesh_pkg::emesh_packet_t rsp_packet_in,
  output logic                     rsp_wait_out,
  output logic                     rsp_access_out,
  output emesh_pkg::emesh_packet_t rsp_packet_out,
  input  logic                     rsp_wait_in
);

  // Requests written on clk_in
  fifo_cdc u_req_cdc (
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .access_in  (req_access_in),
    .packet_in  (req_packet_in),
    .wait_out   (req_wait_out),
    .clk_out    (clk_out),
    .reset_out  (reset_out),
    .access_out (req_access_out),
    .packet_out (req_packet_out),
    .wait_in    (req_wait_in)
  );

  // Responses written on clk_out, clocks swapped
  fifo_cdc u_rsp_cdc (
    .clk_in     (clk_out),
    .reset_in   (reset_out),
    .access_in  (rsp_access_in),
    .packet_in  (rsp_packet_in),
    .wait_out   (rsp_wait_out),
    .clk_out    (clk_in),
    .reset_out  (reset_in),
    .access_out (rsp_access_out),
    .packet_out (rsp_packet_out),
    .wait_in    (rsp_wait_in)
  );

endmodule

/* tb_emesh_cdc_bridge.sv */
// Directed testbench for the mesh CDC bridge with clk_in at 14 ns and clk_out at 20 ns
// Phases drift so crossing latency is waited for and never counted exactly
`timescale 1ns/1ps
`include "emesh_defs.svh"

module tb_emesh_cdc_bridge;

  localparam int TIMEOUT_CYCLES = 3000; // Several times the full run length in clk_out cycles

  logic                     clk_in;
  logic                     clk_out;
  logic                     reset_in;
  logic                     reset_out;
  logic                     req_access_in;
  emesh_pkg::emesh_packet_t req_packet_in;
  logic                     req_wait_out;
  logic                     req_access_out;
  emesh_pkg::emesh_packet_t req_packet_out;
  logic                     req_wait_in;
  logic                     rsp_access_in;
  emesh_pkg::emesh_packet_t rsp_packet_in;
  logic                     rsp_wait_out;
  logic                     rsp_access_out;
  emesh_pkg::emesh_packet_t rsp_packet_out;
  logic                     rsp_wait_in;

  emesh_pkg::emesh_packet_t req_q[$]; // Sent and not yet received
  emesh_pkg::emesh_packet_t rsp_q[$];
  int errors;
  int checks;
  int cycles;

  emesh_cdc_bridge u_emesh_cdc_bridge (
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .clk_out        (clk_out),
    .reset_out      (reset_out),
    .req_access_in  (req_access_in),
    .req_packet_in  (req_packet_in),
    .req_wait_out   (req_wait_out),
    .req_access_out (req_access_out),
    .req_packet_out (req_packet_out),
    .req_wait_in    (req_wait_in),
    .rsp_access_in  (rsp_access_in),
    .rsp_packet_in  (rsp_packet_in),
    .rsp_wait_out   (rsp_wait_out),
    .rsp_access_out (rsp_access_out),
    .rsp_packet_out (rsp_packet_out),
    .rsp_wait_in    (rsp_wait_in)
  );

  initial begin
    clk_out = 1'b0;
    forever #10 clk_out = ~clk_out;
  end

  initial begin
    clk_in = 1'b0;
    forever #7 clk_in = ~clk_in; // Drifts against clk_out
  end

  task automatic check_packet(input string name, input emesh_pkg::emesh_packet_t got,
                              input emesh_pkg::emesh_packet_t exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic emesh_pkg::emesh_packet_t rand_packet();
    emesh_pkg::emesh_packet_t p;
    logic [31:0] r;
    r          = $urandom();
    p.write    = r[7];
    p.datamode = emesh_pkg::datamode_t'(r[1:0]);
    p.ctrlmode = r[6:2];
    p.dstaddr  = $urandom();
    p.data     = $urandom();
    p.srcaddr  = $urandom();
    return p;
  endfunction

  // Sender stops while wait_out is seen high
  task automatic send_req(input int n);
    emesh_pkg::emesh_packet_t p;
    int i;
    i = 0;
    while (i < n) begin
      @(posedge clk_in);
      #1;
      if (req_wait_out) begin
        req_access_in = 1'b0;
      end else begin
        p = rand_packet();
        req_access_in = 1'b1;
        req_packet_in = p;
        req_q.push_back(p);
        i++;
      end
    end
    @(posedge clk_in);
    #1;
    req_access_in = 1'b0;
  endtask

  task automatic send_rsp(input int n);
    emesh_pkg::emesh_packet_t p;
    int i;
    i = 0;
    while (i < n) begin
      @(posedge clk_out);
      #1;
      if (rsp_wait_out) begin
        rsp_access_in = 1'b0;
      end else begin
        p = rand_packet();
        rsp_access_in = 1'b1;
        rsp_packet_in = p;
        rsp_q.push_back(p);
        i++;
      end
    end
    @(posedge clk_out);
    #1;
    rsp_access_in = 1'b0;
  endtask

  // Access high and wait low at negedge means a transfer at the next edge
  task automatic watch_req();
    forever begin
      @(negedge clk_out);
      if (req_access_out && !req_wait_in) begin
        if (req_q.size() == 0) begin
          $display("ERROR: request packet received with none outstanding");
          errors++;
        end else begin
          check_packet("req_packet_out", req_packet_out, req_q.pop_front());
        end
      end
    end
  endtask

  task automatic watch_rsp();
    forever begin
      @(negedge clk_in);
      if (rsp_access_out && !rsp_wait_in) begin
        if (rsp_q.size() == 0) begin
          $display("ERROR: response packet received with none outstanding");
          errors++;
        end else begin
          check_packet("rsp_packet_out", rsp_packet_out, rsp_q.pop_front());
        end
      end
    end
  endtask

  task automatic watchdog();
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_out);
      cycles++;
    end
    $display("ERROR: timeout after %0d clk_out cycles, a channel stopped delivering", cycles);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic wait_drained();
    while (req_q.size() != 0 || rsp_q.size() != 0) @(posedge clk_out);
  endtask

  // Stall first so the FIFO backs up, then freeze a live packet on the output
  task automatic hold_req(input int n);
    logic held_acc;
    emesh_pkg::emesh_packet_t held_pkt;
    @(posedge clk_out);
    #1;
    req_wait_in = 1'b1;
    repeat (8) @(posedge clk_out);
    #1;
    req_wait_in = 1'b0;
    while (!req_access_out) @(negedge clk_out);
    @(posedge clk_out);
    #1;
    req_wait_in = 1'b1;
    @(negedge clk_out);
    held_acc = req_access_out;
    held_pkt = req_packet_out;
    check_bit("req_access_out", held_acc, 1'b1);
    repeat (n) begin
      @(negedge clk_out);
      check_bit("req_access_out", req_access_out, held_acc);
      check_packet("req_packet_out", req_packet_out, held_pkt);
    end
    @(posedge clk_out);
    #1;
    req_wait_in = 1'b0;
  endtask

  task automatic hold_rsp(input int n);
    logic held_acc;
    emesh_pkg::emesh_packet_t held_pkt;
    @(posedge clk_in);
    #1;
    rsp_wait_in = 1'b1;
    repeat (8) @(posedge clk_in);
    #1;
    rsp_wait_in = 1'b0;
    while (!rsp_access_out) @(negedge clk_in);
    @(posedge clk_in);
    #1;
    rsp_wait_in = 1'b1;
    @(negedge clk_in);
    held_acc = rsp_access_out;
    held_pkt = rsp_packet_out;
    check_bit("rsp_access_out", held_acc, 1'b1);
    repeat (n) begin
      @(negedge clk_in);
      check_bit("rsp_access_out", rsp_access_out, held_acc);
      check_packet("rsp_packet_out", rsp_packet_out, held_pkt);
    end
    @(posedge clk_in);
    #1;
    rsp_wait_in = 1'b0;
  endtask

  task automatic test_reset_state();
    check_bit("req_access_out", req_access_out, 1'b0);
    check_bit("rsp_access_out", rsp_access_out, 1'b0);
    check_bit("req_wait_out", req_wait_out, 1'b0);
    check_bit("rsp_wait_out", rsp_wait_out, 1'b0);
  endtask

  task automatic test_single_packets();
    repeat (3) begin
      send_req(1);
      wait_drained();
    end
  endtask

  task automatic test_burst_order();
    send_req(12);
    wait_drained();
  endtask

  task automatic test_backpressure_hold();
    fork
      send_req(10);
      hold_req(8);
    join
    wait_drained();
  endtask

  task automatic test_almost_full();
    emesh_pkg::emesh_packet_t p;
    int n;
    int k;
    n = 0;
    @(posedge clk_out);
    #1;
    req_wait_in = 1'b1; // Nothing drains while filling
    @(posedge clk_in);
    #1;
    while (!req_wait_out && n < `EMESH_FIFO_DEPTH) begin
      p = rand_packet();
      req_access_in = 1'b1;
      req_packet_in = p;
      req_q.push_back(p);
      n++;
      @(posedge clk_in);
      #1;
    end
    req_access_in = 1'b0;
    check_bit("req_wait_out", req_wait_out, 1'b1);
    if (n > `EMESH_FIFO_DEPTH - `EMESH_PROG_MARGIN + 2) begin
      $display("ERROR: req_wait_out rose only after %0d writes", n);
      errors++;
    end
    @(posedge clk_out);
    #1;
    req_wait_in = 1'b0;
    wait_drained();
    k = 0;
    while (req_wait_out && k < 20) begin // Falls once the read pointer syncs back
      @(negedge clk_in);
      k++;
    end
    check_bit("req_wait_out", req_wait_out, 1'b0);
  endtask

  task automatic test_both_channels();
    fork
      send_req(14);
      send_rsp(14);
      hold_rsp(6);
    join
    wait_drained();
  endtask

  initial begin
    reset_in      = 1'b1;
    reset_out     = 1'b1;
    req_access_in = 1'b0;
    req_packet_in = '0;
    req_wait_in   = 1'b0;
    rsp_access_in = 1'b0;
    rsp_packet_in = '0;
    rsp_wait_in   = 1'b0;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    void'($urandom(32'h4b0b));
    fork
      watchdog();
      watch_req();
      watch_rsp();
    join_none
    repeat (2) @(posedge clk_out);
    #1;
    reset_out = 1'b0;
    @(posedge clk_in);
    #1;
    reset_in = 1'b0;
    test_reset_state();
    test_single_packets();
    test_burst_order();
    test_backpressure_hold();
    test_almost_full();
    test_both_channels();
    repeat (10) @(posedge clk_out); // Catch any late duplicate
    $display("Summary: %0d checks, %0d errors, %0d clk_out cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
emesh_pkg.sv
fifo_async.sv
fifo_cdc.sv
emesh_cdc_bridge.sv
tb_emesh_cdc_bridge.sv

/* Makefile */
# Verilator build and run for the mesh CDC bridge testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_emesh_cdc_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = emesh_defs.svh emesh_pkg.sv fifo_async.sv fifo_cdc.sv \
          emesh_cdc_bridge.sv tb_emesh_cdc_bridge.sv

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
